/* board_pkg.sv */
package board_pkg;

  // Shared bus geometry.
  localparam int unsigned ADDR_W = 4;
  localparam int unsigned DATA_W = 8;

  // Address bit 3 picks the slave. 0 is misc_regs, 1 is the scratch RAM.
  localparam int unsigned SLV_SEL_BIT = 3;

  // Misc register offsets.
  localparam logic [2:0] REG_RESET       = 3'd0;
  localparam logic [2:0] REG_SYSCONFIG_0 = 3'd1;
  localparam logic [2:0] REG_SYSCONFIG_1 = 3'd2;
  localparam logic [2:0] REG_SELECTMAP   = 3'd3;
  localparam logic [2:0] REG_FLASH       = 3'd4;
  localparam logic [2:0] REG_LEDS        = 3'd5;

  // Bit positions inside RESET.
  localparam int unsigned BIT_POR_FORCE  = 0;
  localparam int unsigned BIT_GETH_RESET = 1;

  // Bit position inside SELECTMAP. Bit 0 reflects the busy input.
  localparam int unsigned BIT_SCONF_DISABLE = 1;

  // Bit positions inside FLASH. Bit 0 reflects flash_busy.
  localparam int unsigned BIT_FLASH_WP   = 4;
  localparam int unsigned BIT_EEPROM0_WP = 5;
  localparam int unsigned BIT_EEPROM1_WP = 6;

  // Scratch memory size in bytes.
  localparam int unsigned RAM_DEPTH = 8;

endpackage

/* wb_if.sv */
`timescale 1ns/1ps

interface wb_if;

  logic                          cyc;
  logic                          stb;
  logic                          we;
  logic [board_pkg::ADDR_W-1:0]  adr;
  logic [board_pkg::DATA_W-1:0]  dat_w;
  logic [board_pkg::DATA_W-1:0]  dat_r;
  logic                          ack;

  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    input  dat_r,
    input  ack
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    output dat_r,
    output ack
  );

endinterface

/* wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  wb_if.slave  m0,
  wb_if.slave  m1,
  wb_if.master bus
);

  logic gnt_valid_q;
  // Selected master while granted, the last one served while idle.
  logic gnt_sel_q;
  logic sel_cyc;
  logic next_sel;
  logic gnt_m0;
  logic gnt_m1;

  assign sel_cyc = gnt_sel_q ? m1.cyc : m0.cyc;

  // Round robin on a tie, otherwise whoever is asking.
  always_comb begin
    if (m0.cyc && m1.cyc) begin
      next_sel = ~gnt_sel_q;
    end else begin
      next_sel = m1.cyc;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      gnt_valid_q <= 1'b0;
      // Marks m1 as served last so m0 wins the first tie.
      gnt_sel_q   <= 1'b1;
    end else if (gnt_valid_q) begin
      if (!sel_cyc) begin
        gnt_valid_q <= 1'b0;
      end
    end else if (m0.cyc || m1.cyc) begin
      gnt_valid_q <= 1'b1;
      gnt_sel_q   <= next_sel;
    end
  end

  assign gnt_m0 = gnt_valid_q & ~gnt_sel_q;
  assign gnt_m1 = gnt_valid_q & gnt_sel_q;

  // Request path to the shared bus.
  assign bus.cyc   = gnt_valid_q & sel_cyc;
  assign bus.stb   = gnt_valid_q & (gnt_sel_q ? m1.stb : m0.stb);
  assign bus.we    = gnt_sel_q ? m1.we : m0.we;
  assign bus.adr   = gnt_sel_q ? m1.adr : m0.adr;
  assign bus.dat_w = gnt_sel_q ? m1.dat_w : m0.dat_w;

  // The waiting master sees no ack.
  assign m0.ack   = gnt_m0 & bus.ack;
  assign m1.ack   = gnt_m1 & bus.ack;
  assign m0.dat_r = gnt_m0 ? bus.dat_r : '0;
  assign m1.dat_r = gnt_m1 ? bus.dat_r : '0;

endmodule

/* wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder (
  wb_if.slave  bus,
  wb_if.master misc,
  wb_if.master ram
);

  logic                                   ram_sel;
  logic [board_pkg::ADDR_W-1:0]           slv_adr;

  assign ram_sel = bus.adr[board_pkg::SLV_SEL_BIT];

  // Slaves only see the offset below the select bit.
  assign slv_adr = {
    {(board_pkg::ADDR_W - board_pkg::SLV_SEL_BIT){1'b0}},
    bus.adr[board_pkg::SLV_SEL_BIT-1:0]
  };

  // Misc register block.
  assign misc.cyc   = bus.cyc;
  assign misc.stb   = bus.stb & ~ram_sel;
  assign misc.we    = bus.we;
  assign misc.adr   = slv_adr;
  assign misc.dat_w = bus.dat_w;

  // Scratch RAM.
  assign ram.cyc   = bus.cyc;
  assign ram.stb   = bus.stb & ram_sel;
  assign ram.we    = bus.we;
  assign ram.adr   = slv_adr;
  assign ram.dat_w = bus.dat_w;

  // Return path from the addressed slave.
  always_comb begin
    if (ram_sel) begin
      bus.ack   = ram.ack;
      bus.dat_r = ram.dat_r;
    end else begin
      bus.ack   = misc.ack;
      bus.dat_r = misc.dat_r;
    end
  end

endmodule

/* misc_regs.sv */
`timescale 1ns/1ps

module misc_regs (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  wb_if.slave        bus,
  input  logic [7:0] sys_config_i,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  input  logic       flash_busy_i,
  input  logic       serial_conf_busy_i,
  output logic       por_force_o,
  output logic       geth_reset_o,
  output logic       serial_conf_disable_o,
  output logic       flash_wp_o,
  output logic       eeprom_0_wp_o,
  output logic       eeprom_1_wp_o,
  output logic [1:0] user_led_o
);

  logic       ack_q;
  logic       trans;
  logic [2:0] offset;

  assign offset = bus.adr[2:0];

  // One ack per transfer, even with stb held.
  assign trans = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q                 <= 1'b0;
      por_force_o           <= 1'b0;
      geth_reset_o          <= 1'b0;
      serial_conf_disable_o <= 1'b0;
      flash_wp_o            <= 1'b0;
      eeprom_0_wp_o         <= 1'b0;
      eeprom_1_wp_o         <= 1'b0;
      user_led_o            <= 2'b00;
    end else begin
      ack_q <= trans;
      if (trans && bus.we) begin
        case (offset)
          board_pkg::REG_RESET: begin
            por_force_o  <= bus.dat_w[board_pkg::BIT_POR_FORCE];
            geth_reset_o <= bus.dat_w[board_pkg::BIT_GETH_RESET];
          end
          board_pkg::REG_SELECTMAP: begin
            serial_conf_disable_o <= bus.dat_w[board_pkg::BIT_SCONF_DISABLE];
          end
          board_pkg::REG_FLASH: begin
            flash_wp_o    <= bus.dat_w[board_pkg::BIT_FLASH_WP];
            eeprom_0_wp_o <= bus.dat_w[board_pkg::BIT_EEPROM0_WP];
            eeprom_1_wp_o <= bus.dat_w[board_pkg::BIT_EEPROM1_WP];
          end
          board_pkg::REG_LEDS: begin
            user_led_o <= bus.dat_w[1:0];
          end
          // SYSCONFIG and unmapped offsets ignore writes.
          default: begin
          end
        endcase
      end
    end
  end

  assign bus.ack = ack_q;

  // Read word for the addressed register.
  always_comb begin
    bus.dat_r = '0;
    case (offset)
      board_pkg::REG_RESET: begin
        bus.dat_r[board_pkg::BIT_POR_FORCE]  = por_force_o;
        bus.dat_r[board_pkg::BIT_GETH_RESET] = geth_reset_o;
      end
      board_pkg::REG_SYSCONFIG_0: begin
        bus.dat_r = {config_dip_i, user_dip_i};
      end
      board_pkg::REG_SYSCONFIG_1: begin
        bus.dat_r = sys_config_i;
      end
      board_pkg::REG_SELECTMAP: begin
        bus.dat_r[0]                            = serial_conf_busy_i;
        bus.dat_r[board_pkg::BIT_SCONF_DISABLE] = serial_conf_disable_o;
      end
      board_pkg::REG_FLASH: begin
        bus.dat_r[0]                         = flash_busy_i;
        bus.dat_r[board_pkg::BIT_FLASH_WP]   = flash_wp_o;
        bus.dat_r[board_pkg::BIT_EEPROM0_WP] = eeprom_0_wp_o;
        bus.dat_r[board_pkg::BIT_EEPROM1_WP] = eeprom_1_wp_o;
      end
      board_pkg::REG_LEDS: begin
        bus.dat_r[1:0] = user_led_o;
      end
      default: begin
        bus.dat_r = '0;
      end
    endcase
  end

endmodule

/* wb_scratch_ram.sv */
`timescale 1ns/1ps

module wb_scratch_ram (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  wb_if.slave  bus
);

  localparam int unsigned RAM_AW = $clog2(board_pkg::RAM_DEPTH);

  logic [board_pkg::DATA_W-1:0] mem [board_pkg::RAM_DEPTH];
  logic                         ack_q;
  logic                         trans;
  logic [RAM_AW-1:0]            idx;

  assign idx   = bus.adr[RAM_AW-1:0];
  assign trans = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= trans;
    end
  end

  // Contents survive reset.
  always_ff @(posedge wb_clk_i) begin
    if (trans && bus.we) begin
      mem[idx] <= bus.dat_w;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = mem[idx];

endmodule

/* board_ctrl_top.sv */
`timescale 1ns/1ps

module board_ctrl_top (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,

  // Host port.
  input  logic       m0_cyc_i,
  input  logic       m0_stb_i,
  input  logic       m0_we_i,
  input  logic [3:0] m0_adr_i,
  input  logic [7:0] m0_dat_i,
  output logic [7:0] m0_dat_o,
  output logic       m0_ack_o,

  // Debug port.
  input  logic       m1_cyc_i,
  input  logic       m1_stb_i,
  input  logic       m1_we_i,
  input  logic [3:0] m1_adr_i,
  input  logic [7:0] m1_dat_i,
  output logic [7:0] m1_dat_o,
  output logic       m1_ack_o,

  // Board pins.
  input  logic [7:0] sys_config_i,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  input  logic       flash_busy_i,
  input  logic       serial_conf_busy_i,
  output logic       por_force_o,
  output logic       geth_reset_o,
  output logic       serial_conf_disable_o,
  output logic       flash_wp_o,
  output logic       eeprom_0_wp_o,
  output logic       eeprom_1_wp_o,
  output logic [1:0] user_led_o
);

  wb_if m0_wb ();
  wb_if m1_wb ();
  wb_if bus_wb ();
  wb_if misc_wb ();
  wb_if ram_wb ();

  assign m0_wb.cyc   = m0_cyc_i;
  assign m0_wb.stb   = m0_stb_i;
  assign m0_wb.we    = m0_we_i;
  assign m0_wb.adr   = m0_adr_i;
  assign m0_wb.dat_w = m0_dat_i;
  assign m0_dat_o    = m0_wb.dat_r;
  assign m0_ack_o    = m0_wb.ack;

  assign m1_wb.cyc   = m1_cyc_i;
  assign m1_wb.stb   = m1_stb_i;
  assign m1_wb.we    = m1_we_i;
  assign m1_wb.adr   = m1_adr_i;
  assign m1_wb.dat_w = m1_dat_i;
  assign m1_dat_o    = m1_wb.dat_r;
  assign m1_ack_o    = m1_wb.ack;

  wb_arbiter u_arbiter (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .m0       (m0_wb),
    .m1       (m1_wb),
    .bus      (bus_wb)
  );

  wb_decoder u_decoder (
    .bus  (bus_wb),
    .misc (misc_wb),
    .ram  (ram_wb)
  );

  misc_regs u_misc_regs (
    .wb_clk_i              (wb_clk_i),
    .wb_rst_i              (wb_rst_i),
    .bus                   (misc_wb),
    .sys_config_i          (sys_config_i),
    .user_dip_i            (user_dip_i),
    .config_dip_i          (config_dip_i),
    .flash_busy_i          (flash_busy_i),
    .serial_conf_busy_i    (serial_conf_busy_i),
    .por_force_o           (por_force_o),
    .geth_reset_o          (geth_reset_o),
    .serial_conf_disable_o (serial_conf_disable_o),
    .flash_wp_o            (flash_wp_o),
    .eeprom_0_wp_o         (eeprom_0_wp_o),
    .eeprom_1_wp_o         (eeprom_1_wp_o),
    .user_led_o            (user_led_o)
  );

  wb_scratch_ram u_scratch_ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus      (ram_wb)
  );

endmodule

/* tb_board_ctrl.sv */
`timescale 1ns/1ps

module tb_board_ctrl;

  localparam int N_REG  = 24;
  localparam int N_PIN  = 8;
  localparam int N_RAM  = 32;
  localparam int N_CONC = 24;
  // Reset reads, register write/read pairs, pin reads, RAM fill and traffic,
  // up to three transfers per concurrent round, and the final readback.
  localparam int N_XFERS    = 4 + 2 * N_REG + 4 * N_PIN + 8 + N_RAM + 3 * N_CONC + 16;
  localparam int MAX_CYCLES = N_XFERS * 20;

  logic       wb_clk_i = 1'b0;
  logic       wb_rst_i;
  logic       m0_cyc_i, m0_stb_i, m0_we_i;
  logic [3:0] m0_adr_i;
  logic [7:0] m0_dat_i;
  logic [7:0] m0_dat_o;
  logic       m0_ack_o;
  logic       m1_cyc_i, m1_stb_i, m1_we_i;
  logic [3:0] m1_adr_i;
  logic [7:0] m1_dat_i;
  logic [7:0] m1_dat_o;
  logic       m1_ack_o;
  logic [7:0] sys_config_i;
  logic [3:0] user_dip_i;
  logic [3:0] config_dip_i;
  logic       flash_busy_i;
  logic       serial_conf_busy_i;
  logic       por_force_o, geth_reset_o, serial_conf_disable_o;
  logic       flash_wp_o, eeprom_0_wp_o, eeprom_1_wp_o;
  logic [1:0] user_led_o;
  logic [7:0] pin_state;

  // Model of the control bits, the RAM and the arbiter's last-served master.
  logic       m_por, m_geth, m_sconf, m_fwp, m_ee0, m_ee1;
  logic [1:0] m_leds;
  logic [7:0] m_ram [8];
  logic       last_served;

  logic [31:0] rng_state = 32'h090a_a699;
  int          cycle_cnt  = 0;
  int          host_xfers = 0;
  int          debug_xfers = 0;
  int          host_acks  = 0;
  int          debug_acks = 0;

  board_ctrl_top DUT (.*);

  assign pin_state = {eeprom_1_wp_o, eeprom_0_wp_o, flash_wp_o, serial_conf_disable_o,
                      geth_reset_o, por_force_o, user_led_o};

  always #5 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: no end of test after %0d clock cycles.", cycle_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "A transfer never completed.");
    end
  end

  always @(posedge wb_clk_i) begin
    if (m0_ack_o) host_acks <= host_acks + 1;
    if (m1_ack_o) debug_acks <= debug_acks + 1;
  end

  function logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  // Read word layout of each register, built from the model and the live pins.
  function logic [7:0] expected_read(input logic [3:0] adr);
    if (adr[3]) return m_ram[adr[2:0]];
    case (adr[2:0])
      3'd0:    return {6'b0, m_geth, m_por};
      3'd1:    return {config_dip_i, user_dip_i};
      3'd2:    return sys_config_i;
      3'd3:    return {6'b0, m_sconf, serial_conf_busy_i};
      3'd4:    return {1'b0, m_ee1, m_ee0, m_fwp, 3'b0, flash_busy_i};
      3'd5:    return {6'b0, m_leds};
      default: return 8'h00;
    endcase
  endfunction

  function logic [7:0] expected_pins();
    return {m_ee1, m_ee0, m_fwp, m_sconf, m_geth, m_por, m_leds};
  endfunction

  task automatic model_write(input logic [3:0] adr, input logic [7:0] d);
    if (adr[3]) begin
      m_ram[adr[2:0]] = d;
    end else begin
      case (adr[2:0])
        3'd0: begin
          m_por  = d[0];
          m_geth = d[1];
        end
        3'd3: m_sconf = d[1];
        3'd4: begin
          m_fwp = d[4];
          m_ee0 = d[5];
          m_ee1 = d[6];
        end
        3'd5: m_leds = d[1:0];
        default: ;
      endcase
    end
  endtask

  task automatic reset_dut();
    wb_rst_i <= 1'b1;
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    {m_por, m_geth, m_sconf, m_fwp, m_ee0, m_ee1, m_leds} = '0;
    // After reset m0 wins the first tie.
    last_served = 1'b1;
  endtask

  task automatic host_xfer(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat, output int ack_cyc);
    @(posedge wb_clk_i);
    m0_cyc_i <= 1'b1;
    m0_stb_i <= 1'b1;
    m0_we_i  <= we;
    m0_adr_i <= adr;
    m0_dat_i <= wdat;
    @(posedge wb_clk_i);
    while (!m0_ack_o) @(posedge wb_clk_i);
    rdat    = m0_dat_o;
    ack_cyc = cycle_cnt;
    m0_cyc_i <= 1'b0;
    m0_stb_i <= 1'b0;
    host_xfers++;
    last_served = 1'b0;
  endtask

  task automatic debug_xfer(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat, output int ack_cyc);
    @(posedge wb_clk_i);
    m1_cyc_i <= 1'b1;
    m1_stb_i <= 1'b1;
    m1_we_i  <= we;
    m1_adr_i <= adr;
    m1_dat_i <= wdat;
    @(posedge wb_clk_i);
    while (!m1_ack_o) @(posedge wb_clk_i);
    rdat    = m1_dat_o;
    ack_cyc = cycle_cnt;
    m1_cyc_i <= 1'b0;
    m1_stb_i <= 1'b0;
    debug_xfers++;
    last_served = 1'b1;
  endtask

  task automatic do_xfer(input logic port, input logic we, input logic [3:0] adr,
                         input logic [7:0] wdat, output logic [7:0] rdat);
    int ac;
    if (port) debug_xfer(we, adr, wdat, rdat, ac);
    else host_xfer(we, adr, wdat, rdat, ac);
  endtask

  task automatic read_check(input logic port, input logic [3:0] adr, input string name);
    logic [7:0] rd;
    do_xfer(port, 1'b0, adr, 8'h00, rd);
    check_value($sformatf("%s adr %0d", name, adr), expected_read(adr), rd);
  endtask

  task automatic check_reset_state();
    check_value("pins after reset", 0, pin_state);
    read_check(1'b0, 4'd0, "reset read");
    read_check(1'b0, 4'd3, "reset read");
    read_check(1'b0, 4'd4, "reset read");
    read_check(1'b0, 4'd5, "reset read");
  endtask

  task automatic exercise_reg_writes();
    logic [15:0] r;
    logic [7:0]  rd;
    for (int i = 0; i < N_REG; i++) begin
      r = lcg_next();
      do_xfer(1'b0, 1'b1, {1'b0, r[2:0]}, r[15:8], rd);
      model_write({1'b0, r[2:0]}, r[15:8]);
      check_value($sformatf("pins after write %0d", i), expected_pins(), pin_state);
      read_check(1'b0, {1'b0, r[2:0]}, "register readback");
    end
  endtask

  task automatic sweep_pin_inputs();
    logic [15:0] r;
    logic [15:0] r2;
    for (int i = 0; i < N_PIN; i++) begin
      r  = lcg_next();
      r2 = lcg_next();
      @(posedge wb_clk_i);
      sys_config_i       <= r[7:0];
      user_dip_i         <= r[11:8];
      config_dip_i       <= r[15:12];
      flash_busy_i       <= r2[0];
      serial_conf_busy_i <= r2[1];
      for (int off = 1; off <= 4; off++) begin
        read_check(r2[2], off[3:0], "pin reflection");
      end
    end
  endtask

  task automatic ram_traffic();
    logic [15:0] r;
    logic [7:0]  rd;
    // RAM is not reset, so give every byte a known value first.
    for (int a = 0; a < 8; a++) begin
      r = lcg_next();
      do_xfer(a[0], 1'b1, {1'b1, a[2:0]}, r[7:0], rd);
      model_write({1'b1, a[2:0]}, r[7:0]);
    end
    for (int i = 0; i < N_RAM; i++) begin
      r = lcg_next();
      do_xfer(r[0], r[1], {1'b1, r[4:2]}, r[15:8], rd);
      if (r[1]) model_write({1'b1, r[4:2]}, r[15:8]);
      else check_value($sformatf("ram read %0d", i), expected_read({1'b1, r[4:2]}), rd);
    end
  endtask

  task automatic apply_op(input string name, input logic we, input logic [3:0] adr,
                          input logic [7:0] wdat, input logic [7:0] rd);
    if (we) model_write(adr, wdat);
    else check_value(name, expected_read(adr), rd);
  endtask

  task automatic concurrent_traffic();
    logic [15:0] r1;
    logic [15:0] r2;
    logic [3:0]  h_adr, d_adr;
    logic [7:0]  h_rd, d_rd;
    int          h_ac, d_ac;
    logic        winner;
    reset_dut();
    check_value("pins after second reset", 0, pin_state);
    for (int i = 0; i < N_CONC; i++) begin
      r1 = lcg_next();
      // A lone host transfer now and then hands the next tie to m1.
      if (r1[0]) read_check(1'b0, r1[7:4], "solo read");
      r1 = lcg_next();
      r2 = lcg_next();
      h_adr  = r1[4:1];
      d_adr  = r2[1] ? h_adr : r2[5:2];
      winner = ~last_served;
      fork
        host_xfer(r1[0], h_adr, r1[15:8], h_rd, h_ac);
        debug_xfer(r2[0], d_adr, r2[15:8], d_rd, d_ac);
      join
      check_value($sformatf("grant order %0d", i), winner, (h_ac < d_ac) ? 1'b0 : 1'b1);
      if (!winner) begin
        apply_op($sformatf("host round %0d", i), r1[0], h_adr, r1[15:8], h_rd);
        apply_op($sformatf("debug round %0d", i), r2[0], d_adr, r2[15:8], d_rd);
      end else begin
        apply_op($sformatf("debug round %0d", i), r2[0], d_adr, r2[15:8], d_rd);
        apply_op($sformatf("host round %0d", i), r1[0], h_adr, r1[15:8], h_rd);
      end
      check_value($sformatf("pins round %0d", i), expected_pins(), pin_state);
    end
    for (int a = 0; a < 16; a++) begin
      read_check(1'b0, a[3:0], "final state");
    end
  endtask

  initial begin
    wb_rst_i           = 1'b1;
    {m0_cyc_i, m0_stb_i, m0_we_i, m0_adr_i, m0_dat_i} = '0;
    {m1_cyc_i, m1_stb_i, m1_we_i, m1_adr_i, m1_dat_i} = '0;
    sys_config_i       = 8'h5a;
    user_dip_i         = 4'h3;
    config_dip_i       = 4'hc;
    flash_busy_i       = 1'b1;
    serial_conf_busy_i = 1'b1;
    reset_dut();
    check_reset_state();
    exercise_reg_writes();
    sweep_pin_inputs();
    ram_traffic();
    concurrent_traffic();
    repeat (3) @(posedge wb_clk_i);
    check_value("host ack count", host_xfers, host_acks);
    check_value("debug ack count", debug_xfers, debug_acks);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* flist.f */
board_pkg.sv
wb_if.sv
wb_arbiter.sv
wb_decoder.sv
misc_regs.sv
wb_scratch_ram.sv
board_ctrl_top.sv
tb_board_ctrl.sv

/* Bender.yml */
package:
  name: board_ctrl

sources:
  - files:
      - board_pkg.sv
      - wb_if.sv
      - wb_arbiter.sv
      - wb_decoder.sv
      - misc_regs.sv
      - wb_scratch_ram.sv
      - board_ctrl_top.sv
  - target: simulation
    files:
      - tb_board_ctrl.sv
